/* source/eth_demux_pkg.sv */
/*
 * Shared definitions for the four-port Ethernet frame demux
 *   port count and field widths
 *   port index and per-port mask types
 *   header struct and payload beat struct
 */

`default_nettype none

package eth_demux_pkg;

    // output port count and index width
    localparam int num_ports = 4;
    localparam int sel_w = 2;

    // header field widths
    localparam int mac_w = 48;
    localparam int type_w = 16;

    // payload byte width
    localparam int data_w = 8;

    typedef logic [sel_w-1:0] port_sel_t;

    // one bit per output port
    typedef logic [num_ports-1:0] port_mask_t;

    // header as it travels on in_hdr and out_hdr
    typedef struct packed {
        logic [mac_w-1:0]  dest_mac;
        logic [mac_w-1:0]  src_mac;
        logic [type_w-1:0] eth_type;
    } eth_hdr_t;

    // one payload byte with its sideband bits
    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
        logic              user;
    } eth_beat_t;

endpackage

`default_nettype wire

/* source/eth_frame_gate.sv */
/*
 * Frame control for the Ethernet demux
 *   start of frame decision from enable and the busy flags
 *   latched port select and frame-open flag
 *   registered header and payload ready toward the source
 */

`default_nettype none

module eth_frame_gate (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    enable,
    input  wire eth_demux_pkg::port_sel_t select,
    input  wire logic                    in_hdr_valid,
    input  wire logic                    in_beat_valid,
    input  wire logic                    in_beat_last,
    input  wire logic                    hdr_busy,
    input  wire logic                    beat_busy,
    input  wire logic                    ready_early,
    output logic                         in_hdr_ready,
    output logic                         in_beat_ready,
    output logic                         in_fire,
    output logic                         start,
    output eth_demux_pkg::port_sel_t     next_port,
    output eth_demux_pkg::port_sel_t     port
);

    import eth_demux_pkg::*;

    port_sel_t port_reg;
    logic      frame_reg;
    logic      frame_next;
    logic      hdr_ready_reg;
    logic      beat_ready_reg;

    assign in_hdr_ready = hdr_ready_reg;
    assign in_beat_ready = beat_ready_reg;
    assign port = port_reg;

    // a beat is taken from the source this cycle
    assign in_fire = in_beat_valid & beat_ready_reg;

    // new frame only when the latched port has drained its header and beat
    assign start = ~frame_reg & enable & in_hdr_valid & ~hdr_busy & ~beat_busy;

    assign next_port = start ? select : port_reg;

    always_comb begin
        frame_next = frame_reg;
        // end of frame on an accepted last beat
        if (in_fire && in_beat_last) begin
            frame_next = 1'b0;
        end
        if (start) begin
            frame_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port_reg <= '0;
            frame_reg <= 1'b0;
            hdr_ready_reg <= 1'b0;
            beat_ready_reg <= 1'b0;
        end else begin
            port_reg <= next_port;
            frame_reg <= frame_next;
            // header ready holds until the source drops valid
            hdr_ready_reg <= (hdr_ready_reg & in_hdr_valid) | start;
            // payload ready looks one cycle ahead at the output side
            beat_ready_reg <= ready_early & frame_next;
        end
    end

endmodule

`default_nettype wire

/* source/eth_hdr_steer.sv */
/*
 * Header steering for the Ethernet demux
 *   header field register broadcast to all ports
 *   per-port header valid flags
 *   busy flag of the latched port
 */

`default_nettype none

module eth_hdr_steer (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,
    input  wire eth_demux_pkg::port_sel_t  next_port,
    input  wire eth_demux_pkg::port_sel_t  port,
    input  wire eth_demux_pkg::eth_hdr_t   in_hdr,
    input  wire eth_demux_pkg::port_mask_t out_hdr_ready,
    output eth_demux_pkg::eth_hdr_t        out_hdr,
    output eth_demux_pkg::port_mask_t      out_hdr_valid,
    output logic                          hdr_busy
);

    import eth_demux_pkg::*;

    eth_hdr_t   hdr_reg;
    port_mask_t valid_reg;
    port_mask_t valid_next;

    assign out_hdr = hdr_reg;
    assign out_hdr_valid = valid_reg;

    // latched port still waits for its header to be taken
    assign hdr_busy = valid_reg[port];

    always_comb begin
        // each flag drops once its port takes the header
        valid_next = valid_reg & ~out_hdr_ready;
        if (start) begin
            valid_next[next_port] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_reg <= '0;
        end else begin
            valid_reg <= valid_next;
        end
    end

    // header fields are shared by every port
    always_ff @(posedge clk) begin
        if (start) begin
            hdr_reg <= in_hdr;
        end
    end

endmodule

`default_nettype wire

/* source/eth_payload_steer.sv */
/*
 * Payload steering for the Ethernet demux
 *   output beat register broadcast to all ports
 *   one-entry skid register for back-pressure
 *   per-port beat valid flags and the early ready term
 */

`default_nettype none

module eth_payload_steer (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire eth_demux_pkg::port_sel_t  port,
    input  wire logic                     in_fire,
    input  wire eth_demux_pkg::eth_beat_t  in_beat,
    input  wire eth_demux_pkg::port_mask_t out_beat_ready,
    output eth_demux_pkg::eth_beat_t       out_beat,
    output eth_demux_pkg::port_mask_t      out_beat_valid,
    output logic                          beat_busy,
    output logic                          ready_early
);

    import eth_demux_pkg::*;

    eth_beat_t  out_reg;
    eth_beat_t  skid_reg;
    logic       skid_valid;
    logic       skid_valid_next;
    port_mask_t valid_reg;
    port_mask_t valid_next;
    port_mask_t port_mask;
    logic       ready_int_reg;
    logic       cur_ready;
    logic       cur_valid;

    // datapath moves
    logic store_in_to_out;
    logic store_in_to_skid;
    logic store_skid_to_out;

    assign out_beat = out_reg;
    assign out_beat_valid = valid_reg;

    // one-hot of the latched port
    assign port_mask = port_mask_t'(1) << port;

    assign cur_ready = out_beat_ready[port];
    assign cur_valid = valid_reg[port];
    assign beat_busy = cur_valid;

    // take a beat next cycle if the port drains now or the skid will stay empty
    assign ready_early = cur_ready | (~skid_valid & (~cur_valid | ~in_fire));

    always_comb begin
        valid_next = valid_reg;
        skid_valid_next = skid_valid;
        store_in_to_out = 1'b0;
        store_in_to_skid = 1'b0;
        store_skid_to_out = 1'b0;

        if (ready_int_reg) begin
            if (cur_ready || !cur_valid) begin
                // output free so the input goes straight out
                valid_next = in_fire ? port_mask : '0;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled so park the input
                skid_valid_next = in_fire;
                store_in_to_skid = 1'b1;
            end
        end else if (cur_ready) begin
            // input blocked, drain the skid entry
            valid_next = skid_valid ? port_mask : '0;
            skid_valid_next = 1'b0;
            store_skid_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_reg <= '0;
            skid_valid <= 1'b0;
            ready_int_reg <= 1'b0;
        end else begin
            valid_reg <= valid_next;
            skid_valid <= skid_valid_next;
            ready_int_reg <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= in_beat;
        end else if (store_skid_to_out) begin
            out_reg <= skid_reg;
        end

        if (store_in_to_skid) begin
            skid_reg <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* source/eth_demux.sv */
/*
 * Top level of the four-port Ethernet frame demux
 *   frame gate for start, end and the latched select
 *   header steering and payload steering side by side
 */

`default_nettype none

module eth_demux (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // frame input
    input  wire eth_demux_pkg::eth_hdr_t   in_hdr,
    input  wire logic                     in_hdr_valid,
    output logic                          in_hdr_ready,
    input  wire eth_demux_pkg::eth_beat_t  in_beat,
    input  wire logic                     in_beat_valid,
    output logic                          in_beat_ready,

    // frame outputs, data shared and valid per port
    output eth_demux_pkg::eth_hdr_t        out_hdr,
    output eth_demux_pkg::port_mask_t      out_hdr_valid,
    input  wire eth_demux_pkg::port_mask_t out_hdr_ready,
    output eth_demux_pkg::eth_beat_t       out_beat,
    output eth_demux_pkg::port_mask_t      out_beat_valid,
    input  wire eth_demux_pkg::port_mask_t out_beat_ready,

    // control
    input  wire logic                     enable,
    input  wire eth_demux_pkg::port_sel_t  select
);

    import eth_demux_pkg::*;

    logic      start;
    logic      in_fire;
    logic      hdr_busy;
    logic      beat_busy;
    logic      ready_early;
    port_sel_t next_port;
    port_sel_t port;

    eth_frame_gate gate_i (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .select        (select),
        .in_hdr_valid  (in_hdr_valid),
        .in_beat_valid (in_beat_valid),
        .in_beat_last  (in_beat.last),
        .hdr_busy      (hdr_busy),
        .beat_busy     (beat_busy),
        .ready_early   (ready_early),
        .in_hdr_ready  (in_hdr_ready),
        .in_beat_ready (in_beat_ready),
        .in_fire       (in_fire),
        .start         (start),
        .next_port     (next_port),
        .port          (port)
    );

    eth_hdr_steer hdr_i (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .next_port     (next_port),
        .port          (port),
        .in_hdr        (in_hdr),
        .out_hdr_ready (out_hdr_ready),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .hdr_busy      (hdr_busy)
    );

    eth_payload_steer payload_i (
        .clk            (clk),
        .rst            (rst),
        .port           (port),
        .in_fire        (in_fire),
        .in_beat        (in_beat),
        .out_beat_ready (out_beat_ready),
        .out_beat       (out_beat),
        .out_beat_valid (out_beat_valid),
        .beat_busy      (beat_busy),
        .ready_early    (ready_early)
    );

endmodule

`default_nettype wire

/* verif/eth_demux_tb.sv */
/*
 * Testbench for the four-port Ethernet frame demux
 *   clock, reset and falling-edge stimulus
 *   random select, frame length and per-port ready
 *   scoreboard with assertions, timeout and report
 */

`default_nettype none

module eth_demux_tb;

    import eth_demux_pkg::*;

    localparam int num_frames = 21;
    localparam int cycle_limit = 40 * num_frames + 200;
    localparam int max_beats = 256;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    eth_hdr_t   in_hdr = '0;
    logic       in_hdr_valid = 1'b0;
    logic       in_hdr_ready;
    eth_beat_t  in_beat = '0;
    logic       in_beat_valid = 1'b0;
    logic       in_beat_ready;
    eth_hdr_t   out_hdr;
    port_mask_t out_hdr_valid;
    port_mask_t out_hdr_ready = '0;
    eth_beat_t  out_beat;
    port_mask_t out_beat_valid;
    port_mask_t out_beat_ready = '0;
    logic       enable = 1'b0;
    port_sel_t  select = '0;

    // expected traffic, written by the stimulus and read by the monitor
    eth_hdr_t  exp_hdr [num_ports];
    eth_beat_t exp_beats [num_ports][max_beats];
    int        hdr_sent [num_ports];
    int        beat_sent [num_ports];
    // progress seen at the outputs
    int        hdr_taken [num_ports];
    int        beat_taken [num_ports];

    int          errors = 0;
    int          tests_run = 0;
    int          cycles = 0;
    logic        gate_low = 1'b0;
    logic        rst_prev = 1'b0;
    logic [31:0] stim_state = 32'hedcb_a146;
    logic [31:0] ready_state = 32'hedcb_a146 ^ 32'h0f0f_0f0f;

    eth_demux dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    task automatic value_mismatch(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic protocol_problem(input string what);
        $display("error at t=%0t: %s", $time, what);
        errors++;
    endtask

    // random back-pressure on every port
    always @(negedge clk) begin
        ready_state = xorshift(ready_state);
        out_hdr_ready = ready_state[3:0];
        out_beat_ready = ready_state[7:4];
    end

    // scoreboard and protocol checks
    always @(posedge clk) begin
        cycles++;
        if (rst_prev) begin
            assert (!in_hdr_ready)
            else value_mismatch("in_hdr_ready", '0, 128'(in_hdr_ready));
            assert (!in_beat_ready)
            else value_mismatch("in_beat_ready", '0, 128'(in_beat_ready));
            assert (out_hdr_valid == 0)
            else value_mismatch("out_hdr_valid", '0, 128'(out_hdr_valid));
            assert (out_beat_valid == 0)
            else value_mismatch("out_beat_valid", '0, 128'(out_beat_valid));
        end else if (!rst) begin
            assert ($onehot0(out_beat_valid))
            else protocol_problem("more than one port shows a valid beat");
            if (gate_low) begin
                assert (!in_hdr_ready)
                else value_mismatch("in_hdr_ready", '0, 128'(in_hdr_ready));
                assert (out_hdr_valid == 0)
                else value_mismatch("out_hdr_valid", '0, 128'(out_hdr_valid));
            end
            for (int k = 0; k < num_ports; k++) begin
                if (out_hdr_valid[k]) begin
                    assert (hdr_sent[k] != hdr_taken[k])
                    else protocol_problem($sformatf("header valid on port %0d without a frame", k));
                    assert (out_hdr == exp_hdr[k])
                    else value_mismatch($sformatf("out_hdr port %0d", k),
                                        128'(exp_hdr[k]), 128'(out_hdr));
                    if (out_hdr_ready[k]) begin
                        hdr_taken[k]++;
                    end
                end
                if (out_beat_valid[k] && out_beat_ready[k]) begin
                    if (beat_taken[k] >= beat_sent[k]) begin
                        protocol_problem($sformatf("unexpected beat on port %0d", k));
                    end else begin
                        assert (out_beat == exp_beats[k][beat_taken[k]])
                        else value_mismatch($sformatf("out_beat port %0d", k),
                                            128'(exp_beats[k][beat_taken[k]]),
                                            128'(out_beat));
                    end
                    beat_taken[k]++;
                end
            end
        end
        rst_prev = rst;
    end

    always @(posedge clk) begin
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with traffic still pending", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic send_frame(input port_sel_t sel, input int len, input int hold_low,
                              input logic move_sel);
        eth_hdr_t    hdr;
        eth_beat_t   beat;
        logic [31:0] r;
        // shared header register, so earlier headers must be taken first
        while (out_hdr_valid != 0) @(negedge clk);
        r = next_rand();
        hdr.dest_mac = {r[15:0], next_rand()};
        r = next_rand();
        hdr.src_mac = {r[15:0], next_rand()};
        r = next_rand();
        hdr.eth_type = r[15:0];
        // enable stays low for at least one edge before each header
        enable = 1'b0;
        select = sel;
        in_hdr = hdr;
        in_hdr_valid = 1'b1;
        @(negedge clk);
        gate_low = 1'b1;
        repeat (hold_low) @(negedge clk);
        gate_low = 1'b0;
        enable = 1'b1;
        while (!in_hdr_ready) @(negedge clk);
        exp_hdr[sel] = hdr;
        hdr_sent[sel]++;
        in_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            beat.data = r[7:0];
            beat.user = r[8];
            beat.last = (i == len - 1);
            exp_beats[sel][beat_sent[sel]] = beat;
            beat_sent[sel]++;
            in_beat = beat;
            in_beat_valid = 1'b1;
            if (move_sel && i == len / 2) begin
                select = sel + 2'd1;
            end
            // ready is registered, so its value now holds through the next edge
            while (!in_beat_ready) @(negedge clk);
            @(negedge clk);
        end
        in_beat_valid = 1'b0;
    endtask

    function automatic logic drained();
        for (int k = 0; k < num_ports; k++) begin
            if (hdr_sent[k] != hdr_taken[k] || beat_sent[k] != beat_taken[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int          mark;
        logic [31:0] r;
        for (int k = 0; k < num_ports; k++) begin
            exp_hdr[k] = '0;
            hdr_sent[k] = 0;
            beat_sent[k] = 0;
            hdr_taken[k] = 0;
            beat_taken[k] = 0;
        end

        mark = errors;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        finish_test("reset", mark);

        mark = errors;
        send_frame(2'd1, 3, 8, 1'b0);
        finish_test("enable gating", mark);

        mark = errors;
        for (int f = 0; f < 16; f++) begin
            r = next_rand();
            send_frame(r[1:0], int'(r[4:2]) + 1, 0, 1'b0);
        end
        finish_test("routing and back-pressure", mark);

        mark = errors;
        for (int f = 0; f < 4; f++) begin
            r = next_rand();
            send_frame(r[1:0], int'(r[4:3]) + 4, 0, 1'b1);
        end
        while (!drained()) @(negedge clk);
        finish_test("latched select", mark);

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eth_demux.f */
source/eth_demux_pkg.sv
source/eth_frame_gate.sv
source/eth_hdr_steer.sv
source/eth_payload_steer.sv
source/eth_demux.sv
verif/eth_demux_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Ethernet demux testbench with Verilator.
# Run from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/eth_demux_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module eth_demux_tb \
    -f eth_demux.f \
    -o eth_demux_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed, see $BUILD_LOG"
    exit 1
fi

"$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1
